// ==== compile.f ====
hdl/linebuf_pkg.sv
hdl/linebuf_ctrl.sv
hdl/line_mem_bank.sv
hdl/line_window.sv
hdl/linebuf_top.sv
test/clk_gen.sv
test/linebuf_properties.sv
test/linebuf_tb.sv

// ==== Makefile ====
SIM      := verilator
FLAGS    := --binary --timing --assert -Wno-fatal -j 0
TOP      := linebuf_tb
FILELIST := compile.f
OBJDIR   := obj_dir
LOG      := sim.log
FAIL_MSG := SIMULATION FAILED

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: compile
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG) || [ $$status -ne 0 ]; then \
	  echo "Run failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJDIR) $(LOG)

// ==== test/linebuf_tb.sv ====
`timescale 1ns/1ps

module linebuf_tb;

  import linebuf_pkg::*;

  localparam int NFRAME  = 5;
  localparam int TIMEOUT = 4000;  // Wait limit in cycles well above the largest frame.
  localparam int IMG_TAB [NFRAME] = '{8, 5, 12, 32, 7};
  localparam int FIL_TAB [NFRAME] = '{3, 5, 2, 5, 4};

  logic    clk;
  logic    xrst;
  size_t   img_size;
  size_t   fil_size;
  logic    req;
  logic    ack;
  pixel_t  pix_in;
  logic    pix_take;
  window_t window;
  logic    win_valid;
  logic    win_start;
  logic    win_stop;

  pixel_t img [MAXIMG][MAXIMG];  // Current frame.
  int     frames_done;

  clk_gen clk_i (
    .clk  (clk),
    .xrst (xrst)
  );

  linebuf_top dut_i (
    .clk       (clk),
    .xrst      (xrst),
    .img_size  (img_size),
    .fil_size  (fil_size),
    .req       (req),
    .ack       (ack),
    .pix_in    (pix_in),
    .pix_take  (pix_take),
    .window    (window),
    .win_valid (win_valid),
    .win_start (win_start),
    .win_stop  (win_stop)
  );

  // Expected window at image position (r, c) with zeros outside fil.
  function automatic window_t ref_window(int r, int c, int fil);
    window_t w;
    w = '0;
    for (int i = 0; i < fil; i++) begin
      for (int j = 0; j < fil; j++) begin
        w.px[i][j] = img[r + i][c + j];
      end
    end
    return w;
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("SIMULATION FAILED");
    $fatal(1, "Testbench stopped on the first error.");
  endtask

  task automatic check_window(input window_t got, input window_t exp, input string what);
    if (got !== exp) begin
      abort_run($sformatf("ERR %0t: %s, got %h expected %h", $time, what, got, exp));
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      abort_run($sformatf("ERR %0t: %s, got %b expected %b", $time, what, got, exp));
    end
  endtask

  task automatic check_count(input int got, input int exp, input string what);
    if (got != exp) begin
      abort_run($sformatf("ERR %0t: %s, got %0d expected %0d", $time, what, got, exp));
    end
  endtask

  task automatic wait_ack();
    int cnt;
    cnt = 0;
    while (ack !== 1'b1) begin
      @(negedge clk);
      cnt++;
      if (cnt > TIMEOUT) begin
        abort_run("Timeout while waiting for ack to rise.");
      end
    end
  endtask

  task automatic fill_image();
    for (int r = 0; r < MAXIMG; r++) begin
      for (int c = 0; c < MAXIMG; c++) begin
        img[r][c] = pixel_t'($urandom);
      end
    end
  endtask

  // Stimulus.
  initial begin
    int n;
    int cnt;
    int pix_cnt;
    void'($urandom(6272));
    req      = 1'b0;
    img_size = '0;
    fil_size = '0;
    pix_in   = '0;
    repeat (3) begin
      @(negedge clk);
      check_flag(ack, 1'b0, "ack in reset");
      check_flag(pix_take, 1'b0, "pix_take in reset");
      check_flag(win_valid | win_start | win_stop, 1'b0, "win strobes in reset");
    end
    for (int f = 0; f < NFRAME; f++) begin
      n = IMG_TAB[f];
      wait_ack();
      fill_image();
      img_size = size_t'(n);
      fil_size = size_t'(FIL_TAB[f]);
      req      = 1'b1;
      cnt      = 0;
      do begin
        @(negedge clk);
        cnt++;
        if (cnt > TIMEOUT) begin
          abort_run("Timeout while holding req for ack to fall.");
        end
      end while (ack);
      req     = 1'b0;
      pix_cnt = 0;
      cnt     = 0;
      while (pix_cnt < n * n) begin
        @(negedge clk);
        cnt++;
        if (pix_take) begin  // Raster order.
          pix_in = img[pix_cnt / n][pix_cnt % n];
          pix_cnt++;
        end
        if (cnt > TIMEOUT) begin
          abort_run("Timeout while waiting for pix_take strobes.");
        end
      end
    end
    cnt = 0;
    while (frames_done < NFRAME && cnt < TIMEOUT) begin
      @(negedge clk);
      cnt++;
    end
    if (frames_done == NFRAME) begin
      $display("SIMULATION PASSED");
      $finish;
    end else begin
      abort_run("Timeout while waiting for the last frame to be checked.");
    end
  end

  // Compare.
  initial begin
    int n;
    int fil;
    int span;
    int cnt;
    int win_cnt;
    int pix_cnt;
    frames_done = 0;
    for (int f = 0; f < NFRAME; f++) begin
      n       = IMG_TAB[f];
      fil     = FIL_TAB[f];
      span    = n - fil + 1;
      cnt     = 0;
      win_cnt = 0;
      pix_cnt = 0;
      do begin
        @(negedge clk);
        cnt++;
        if (cnt > TIMEOUT) begin
          abort_run($sformatf("Timeout while waiting for win_stop of frame %0d.", f));
        end
        if (pix_take) begin
          pix_cnt++;
        end
        if (pix_cnt > 0) begin
          check_flag(ack, 1'b0, "ack during a frame");
        end
        if (win_stop) begin
          check_flag(win_valid, 1'b0, "win_valid with win_stop");
        end
        if (win_valid) begin
          check_flag(win_start, win_cnt == 0, "win_start");
          if (win_cnt >= span * span) begin
            check_count(win_cnt + 1, span * span, "windows in frame");
          end
          check_window(window, ref_window(win_cnt / span, win_cnt % span, fil),
                       $sformatf("frame %0d window %0d", f, win_cnt));
          win_cnt++;
        end else begin
          check_flag(win_start, 1'b0, "win_start without win_valid");
        end
      end while (!win_stop);
      check_count(win_cnt, span * span, "windows in frame");
      check_count(pix_cnt, n * n, "pix_take strobes in frame");
      frames_done++;
    end
  end

endmodule

// ==== test/linebuf_properties.sv ====
`timescale 1ns/1ps

module linebuf_properties (
  input logic                   clk,
  input logic                   xrst,
  input linebuf_pkg::size_t     fil_size,
  input logic                   req,
  input logic                   ack,
  input linebuf_pkg::buf_ctrl_t buf_ctrl,
  input logic                   valid,
  input logic                   start,
  input logic                   stop
);

  import linebuf_pkg::*;

  logic       in_frame;
  logic [1:0] start_cnt;  // Starts since the last stop.

  // True when wsel is one of the fil lines ending at rsel.
  function automatic logic in_rotation(line_t wsel, line_t rsel, size_t fil);
    int idx;
    in_rotation = 1'b0;
    for (int k = 0; k < MAXFIL; k++) begin
      idx = (int'(rsel) - k + BUFLINE) % BUFLINE;
      if (k < int'(fil) && idx == int'(wsel)) begin
        in_rotation = 1'b1;
      end
    end
  endfunction

  always_ff @(posedge clk) begin
    if (!xrst) begin
      in_frame  <= 1'b0;
      start_cnt <= '0;
    end else begin
      if (req && ack) begin
        in_frame <= 1'b1;
      end else if (stop) begin
        in_frame <= 1'b0;
      end
      if (stop) begin
        start_cnt <= '0;
      end else if (start && start_cnt != 2'd3) begin
        start_cnt <= start_cnt + 2'd1;
      end
    end
  end

  a_ack_idle: assert property (@(posedge clk) disable iff (!xrst) in_frame |-> !ack)
    else $error("ack high during a frame");

  // The write two cycles back shares its counter cycle with the read behind this window.
  a_no_overwrite: assert property (@(posedge clk) disable iff (!xrst)
    valid && $past(buf_ctrl.we, 2) |->
      !in_rotation($past(buf_ctrl.wsel, 2), $past(buf_ctrl.rsel), fil_size))
    else $error("write line overlaps the read rotation");

  // Start and the first valid after a stop come together.
  a_start_valid: assert property (@(posedge clk) disable iff (!xrst)
    (start || (valid && start_cnt == 2'd0)) |-> (start && valid))
    else $error("start not on the first valid of the frame");

  a_one_start: assert property (@(posedge clk) disable iff (!xrst) start |-> start_cnt == 2'd0)
    else $error("second start before stop");

  a_stop_start: assert property (@(posedge clk) disable iff (!xrst) stop |-> start_cnt == 2'd1)
    else $error("stop not preceded by exactly one start");

endmodule

bind linebuf_ctrl linebuf_properties props_i (
  .clk      (clk),
  .xrst     (xrst),
  .fil_size (fil_size),
  .req      (req),
  .ack      (ack),
  .buf_ctrl (buf_ctrl),
  .valid    (valid),
  .start    (start),
  .stop     (stop)
);

// ==== test/clk_gen.sv ====
`timescale 1ns/1ps

module clk_gen (
  output logic clk,
  output logic xrst
);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;  // 4 ns period.
  end

  // Reset spans three rising edges and ends on a falling edge.
  initial begin
    xrst = 1'b0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    xrst = 1'b1;
  end

endmodule

// ==== hdl/linebuf_top.sv ====
`timescale 1ns/1ps

module linebuf_top (
  input  logic                 clk,
  input  logic                 xrst,
  input  linebuf_pkg::size_t   img_size,
  input  linebuf_pkg::size_t   fil_size,
  input  logic                 req,
  output logic                 ack,
  input  linebuf_pkg::pixel_t  pix_in,
  output logic                 pix_take,
  output linebuf_pkg::window_t window,
  output logic                 win_valid,
  output logic                 win_start,
  output logic                 win_stop
);

  import linebuf_pkg::*;

  buf_ctrl_t            buf_ctrl;
  pixel_t [BUFLINE-1:0] lines;

  assign pix_take = buf_ctrl.we;  // Pixel is consumed on the write strobe.

  linebuf_ctrl ctrl_i (
    .clk      (clk),
    .xrst     (xrst),
    .img_size (img_size),
    .fil_size (fil_size),
    .req      (req),
    .ack      (ack),
    .buf_ctrl (buf_ctrl),
    .valid    (win_valid),
    .start    (win_start),
    .stop     (win_stop)
  );

  line_mem_bank mem_i (
    .clk      (clk),
    .buf_ctrl (buf_ctrl),
    .pix_in   (pix_in),
    .lines    (lines)
  );

  line_window win_i (
    .clk      (clk),
    .xrst     (xrst),
    .fil_size (fil_size),
    .buf_ctrl (buf_ctrl),
    .lines    (lines),
    .window   (window)
  );

endmodule

// ==== hdl/line_window.sv ====
`timescale 1ns/1ps

module line_window (
  input  logic                                           clk,
  input  logic                                           xrst,
  input  linebuf_pkg::size_t                             fil_size,
  input  linebuf_pkg::buf_ctrl_t                         buf_ctrl,
  input  linebuf_pkg::pixel_t [linebuf_pkg::BUFLINE-1:0] lines,
  output linebuf_pkg::window_t                           window
);

  import linebuf_pkg::*;

  pixel_t [MAXFIL-1:0] col_new;   // New column with index 0 as the oldest row.
  window_t             win_next;

  // Rotate the ring into filter order.
  // Row k comes from the line fil_size-1-k steps behind rsel.
  always_comb begin
    int idx;
    col_new = '0;
    for (int k = 0; k < MAXFIL; k++) begin
      idx = int'(buf_ctrl.rsel) - int'(fil_size) + 1 + k;
      if (idx < 0) begin
        idx = idx + BUFLINE;
      end
      if (k < int'(fil_size)) begin
        col_new[k] = lines[idx];
      end
    end
  end

  // Shift left by one column and put the new column at fil_size-1.
  always_comb begin
    pixel_t [MAXFIL-1:0] row_sh;
    win_next = '0;
    for (int r = 0; r < MAXFIL; r++) begin
      row_sh = window.px[r] >> $bits(pixel_t);
      for (int c = 0; c < MAXFIL; c++) begin
        if (r < int'(fil_size) && c < int'(fil_size)) begin
          if (c == int'(fil_size) - 1) begin
            win_next.px[r][c] = col_new[r];
          end else begin
            win_next.px[r][c] = row_sh[c];
          end
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      window <= '0;
    end else begin
      window <= win_next;  // Parts beyond fil_size stay zero.
    end
  end

endmodule

// ==== hdl/line_mem_bank.sv ====
`timescale 1ns/1ps

module line_mem_bank (
  input  logic                                           clk,
  input  linebuf_pkg::buf_ctrl_t                         buf_ctrl,
  input  linebuf_pkg::pixel_t                            pix_in,
  output linebuf_pkg::pixel_t [linebuf_pkg::BUFLINE-1:0] lines
);

  import linebuf_pkg::*;

  // One memory per ring line.
  for (genvar k = 0; k < BUFLINE; k++) begin : g_line
    pixel_t ram [MAXIMG];
    pixel_t rd_q;
    logic   wr_en;

    assign wr_en = buf_ctrl.we && buf_ctrl.wsel == line_t'(k);

    always_ff @(posedge clk) begin
      if (wr_en) begin
        ram[buf_ctrl.addr] <= pix_in;
      end
      rd_q <= ram[buf_ctrl.addr];  // All lines read at the same column.
    end

    assign lines[k] = rd_q;
  end

endmodule

// ==== hdl/linebuf_ctrl.sv ====
`timescale 1ns/1ps

module linebuf_ctrl (
  input  logic                   clk,
  input  logic                   xrst,
  input  linebuf_pkg::size_t     img_size,
  input  linebuf_pkg::size_t     fil_size,
  input  logic                   req,
  output logic                   ack,
  output linebuf_pkg::buf_ctrl_t buf_ctrl,
  output logic                   valid,
  output logic                   start,
  output logic                   stop
);

  import linebuf_pkg::*;

  typedef enum logic [1:0] {
    S_WAIT,
    S_CHARGE,
    S_ACTIVE
  } state_t;

  state_t     state;
  size_t      col_cnt;
  size_t      row_cnt;    // Runs to img_size, the last value is the flush row.
  line_t      line_cnt;   // Ring line of the row being written.
  line_t      rsel_cnt;   // Ring line of the last finished row.
  line_t      rsel_d;
  logic       flush_done;
  logic [2:0] ack_d;
  logic [2:0] valid_d;
  logic [2:0] start_d;
  logic [2:0] stop_d;
  size_t      img_last;
  size_t      fil_last;
  logic       row_end;
  logic       charge_end;
  logic       active_end;

  assign img_last = img_size - size_t'(1);
  assign fil_last = fil_size - size_t'(1);
  assign row_end  = col_cnt == img_last;

  // Charge stops once fil_size rows sit in the ring.
  assign charge_end = state == S_CHARGE && row_cnt == fil_last && row_end;
  assign active_end = state == S_ACTIVE && row_cnt == img_size && row_end;

  // Ack needs three quiet cycles in wait.
  assign ack = state == S_WAIT && ack_d[2];

  always_ff @(posedge clk) begin
    if (!xrst) begin
      state <= S_WAIT;
    end else begin
      case (state)
        S_WAIT: begin
          if (req && ack) begin
            state <= S_CHARGE;
          end
        end
        S_CHARGE: begin
          if (charge_end) begin
            state <= S_ACTIVE;
          end
        end
        S_ACTIVE: begin
          if (active_end) begin
            state <= S_WAIT;
          end
        end
        default: begin
          state <= S_WAIT;
        end
      endcase
    end
  end

  // Column, row and ring counters.
  always_ff @(posedge clk) begin
    if (!xrst || state == S_WAIT) begin
      col_cnt  <= '0;
      row_cnt  <= '0;
      line_cnt <= '0;
      rsel_cnt <= '0;
    end else if (row_end) begin
      col_cnt  <= '0;
      row_cnt  <= row_cnt + size_t'(1);
      rsel_cnt <= line_cnt;  // Finished row becomes the newest read line.
      if (line_cnt == line_t'(BUFLINE - 1)) begin
        line_cnt <= '0;
      end else begin
        line_cnt <= line_cnt + line_t'(1);
      end
    end else begin
      col_cnt <= col_cnt + size_t'(1);
    end
  end

  // Memory controls, one cycle behind the counters.
  always_ff @(posedge clk) begin
    if (!xrst) begin
      buf_ctrl <= '0;
      rsel_d   <= '0;
    end else begin
      rsel_d        <= rsel_cnt;
      buf_ctrl.rsel <= rsel_d;     // Two stages, lines up with the read data.
      buf_ctrl.wsel <= line_cnt;
      buf_ctrl.addr <= col_cnt[ADDRWIDTH-1:0];
      buf_ctrl.we   <= state != S_WAIT && row_cnt < img_size;  // Flush row writes nothing.
    end
  end

  // Strobes, three stages to match controls, read and window register.
  always_ff @(posedge clk) begin
    if (!xrst) begin
      flush_done <= 1'b0;
      ack_d      <= '0;
      valid_d    <= '0;
      start_d    <= '0;
      stop_d     <= '0;
    end else begin
      flush_done <= active_end;
      ack_d      <= {ack_d[1:0], state == S_WAIT && !flush_done};
      valid_d    <= {valid_d[1:0], state == S_ACTIVE && col_cnt >= fil_last};
      start_d    <= {start_d[1:0],
                     state == S_ACTIVE && row_cnt == fil_size && col_cnt == fil_last};
      stop_d     <= {stop_d[1:0], flush_done};
    end
  end

  assign valid = valid_d[2];
  assign start = start_d[2];
  assign stop  = stop_d[2];

endmodule

// ==== hdl/linebuf_pkg.sv ====
package linebuf_pkg;

  localparam int MAXFIL    = 5;
  localparam int MAXIMG    = 32;
  localparam int BUFLINE   = MAXFIL + 1;          // One spare line takes the incoming row.
  localparam int SIZEWIDTH = $clog2(MAXIMG) + 1;  // Holds MAXIMG itself.
  localparam int LINEWIDTH = $clog2(BUFLINE);
  localparam int ADDRWIDTH = $clog2(MAXIMG);      // Column address inside one line.

  typedef logic [15:0]          pixel_t;
  typedef logic [SIZEWIDTH-1:0] size_t;
  typedef logic [LINEWIDTH-1:0] line_t;

  // Memory controls, registered in the controller.
  typedef struct packed {
    line_t                wsel;  // Line being written.
    line_t                rsel;  // Newest line of the read rotation.
    logic                 we;
    logic [ADDRWIDTH-1:0] addr;
  } buf_ctrl_t;

  // px[row][col], row 0 is the oldest image row and col 0 the leftmost column.
  typedef struct packed {
    pixel_t [MAXFIL-1:0][MAXFIL-1:0] px;
  } window_t;

endpackage
